/* led_matrix_defs.svh */
`ifndef LED_MATRIX_DEFS_SVH
`define LED_MATRIX_DEFS_SVH

// ====================
// matrix geometry
// ====================
`define LED_N_COLS        10
`define LED_N_ROWS        28
`define LED_COL_BITS      4
`define LED_PIX_BITS      5

// ====================
// scan timing
// ====================
`define LED_TIMER_BITS    16
`define LED_LINE_TIME     256
`define LED_LOAD_WAIT     40
`define LED_SHIFT_PERIOD  64

// ====================
// register block
// ====================
// low nibble is the register offset
`define LED_BASE_ADDRESS  16'h0100
`define LED_DEFAULT_FRAME 16'h8000

// row output banks
`define LED_BANKS         4
`define LED_BANK_WIDTH    8

`endif

/* led_bus_pkg.sv */
`default_nettype none

package led_bus_pkg;

  // register offsets within the block
  typedef enum logic [3:0] {
    REG_CTRL   = 4'h0,
    REG_ADDR_L = 4'h2,
    REG_ADDR_H = 4'h3
  } reg_addr_e;

  // byte address on both buses
  typedef logic [15:0] bus_addr_t;

  // register data width of the host bus
  typedef logic [7:0] reg_data_t;

endpackage

`default_nettype wire

/* led_pixel_pkg.sv */
`default_nettype none
`include "led_matrix_defs.svh"

package led_pixel_pkg;

  // rgb565 word, red in the top bits
  typedef union packed {
    logic [15:0] raw;
    struct packed {
      logic [4:0] red;
      logic [5:0] green;
      logic [4:0] blue;
    } rgb;
  } pixel_u;

  // one-hot colour pass
  typedef enum logic [2:0] {
    FIELD_RED   = 3'b001,
    FIELD_GREEN = 3'b010,
    FIELD_BLUE  = 3'b100
  } field_e;

  typedef logic [`LED_TIMER_BITS-1:0] on_time_t;

  // region in [7:6], 6-bit code in [5:0]
  typedef logic [7:0] lut_code_t;

  // square law, peaks at 248 for code 63
  function automatic on_time_t brightness_of(lut_code_t code);
    on_time_t c;
    c = on_time_t'(code[5:0]);
    return (c * c) >> 4;
  endfunction

endpackage

`default_nettype wire

/* led_reg_slave.sv */
`timescale 1ns/1ns
`default_nettype none
`include "led_matrix_defs.svh"

module led_reg_slave (
  input  wire                          clk,
  input  wire                          rst,
  input  wire led_bus_pkg::bus_addr_t  wb_adr_i,
  input  wire led_bus_pkg::reg_data_t  wb_dat_i,
  output led_bus_pkg::reg_data_t       wb_dat_o,
  input  wire                          wb_we_i,
  input  wire                          wb_stb_i,
  input  wire                          wb_cyc_i,
  output logic                         wb_ack_o,
  output led_bus_pkg::bus_addr_t       frame_base_o,
  output logic                         enable_o
);

  logic                   in_range;
  logic                   req;
  logic                   mapped;
  led_bus_pkg::reg_addr_e offset;
  led_bus_pkg::reg_data_t rd_data;

  // ====================
  // address decode
  // ====================
  assign in_range = (wb_adr_i & 16'hFFF0) == `LED_BASE_ADDRESS;
  assign req      = wb_cyc_i && wb_stb_i && in_range;
  assign offset   = led_bus_pkg::reg_addr_e'(wb_adr_i[3:0]);

  always_comb begin
    mapped  = 1'b1;
    rd_data = '0;
    case (offset)
      led_bus_pkg::REG_CTRL:   rd_data = {7'd0, enable_o};
      led_bus_pkg::REG_ADDR_L: rd_data = frame_base_o[7:0];
      led_bus_pkg::REG_ADDR_H: rd_data = frame_base_o[15:8];
      default:                 mapped  = 1'b0;
    endcase
  end

  // read data only while the request is on the bus
  always_comb begin
    wb_dat_o = (req && mapped) ? rd_data : '0;
  end

  // ====================
  // registers
  // ====================
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      enable_o     <= 1'b1;
      frame_base_o <= `LED_DEFAULT_FRAME;
    end else if (req && wb_we_i) begin
      case (offset)
        led_bus_pkg::REG_CTRL:   enable_o           <= wb_dat_i[0];
        led_bus_pkg::REG_ADDR_L: frame_base_o[7:0]  <= wb_dat_i;
        led_bus_pkg::REG_ADDR_H: frame_base_o[15:8] <= wb_dat_i;
        default: ;
      endcase
    end
  end

  // single ack per request, none for holes in the map
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= req && mapped && !wb_ack_o;
    end
  end

endmodule

`default_nettype wire

/* pixel_bus_reader.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_bus_reader (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          fetch_start_i,
  input  wire led_bus_pkg::bus_addr_t  fetch_addr_i,
  output logic                         busy_o,
  output logic                         fetch_done_o,
  output led_pixel_pkg::pixel_u        pixel_o,
  output led_bus_pkg::bus_addr_t       frame_adr_o,
  input  wire [15:0]                   frame_dat_i,
  output logic                         frame_cyc_o,
  output logic                         frame_stb_o,
  input  wire                          frame_ack_i
);

  localparam logic S_IDLE = 1'b0;
  localparam logic S_ACK  = 1'b1;

  logic state;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state        <= S_IDLE;
      fetch_done_o <= 1'b0;
    end else begin
      fetch_done_o <= 1'b0;
      case (state)
        S_IDLE: if (fetch_start_i) state <= S_ACK;
        S_ACK: begin
          // no timeout, memory may stall as long as it likes
          if (frame_ack_i) begin
            state        <= S_IDLE;
            fetch_done_o <= 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // address and pixel capture
  always_ff @(posedge clk) begin
    if (state == S_IDLE && fetch_start_i) begin
      frame_adr_o <= fetch_addr_i;
    end
    if (state == S_ACK && frame_ack_i) begin
      pixel_o.raw <= frame_dat_i;
    end
  end

  assign busy_o      = (state == S_ACK);
  assign frame_cyc_o = (state == S_ACK);
  assign frame_stb_o = (state == S_ACK);

endmodule

`default_nettype wire

/* brightness_lut.sv */
`timescale 1ns/1ns
`default_nettype none

module brightness_lut (
  input  wire                           clk,
  input  wire led_pixel_pkg::pixel_u    pixel_i,
  input  wire led_pixel_pkg::field_e    field_i,
  output led_pixel_pkg::on_time_t       on_time_o
);

  led_pixel_pkg::lut_code_t code;
  led_pixel_pkg::on_time_t  rom [0:255];

  // 5-bit fields padded to 6 bits, region in the top two bits
  always_comb begin
    case (field_i)
      led_pixel_pkg::FIELD_RED:   code = {2'b00, pixel_i.rgb.red, 1'b0};
      led_pixel_pkg::FIELD_GREEN: code = {2'b01, pixel_i.rgb.green};
      led_pixel_pkg::FIELD_BLUE:  code = {2'b10, pixel_i.rgb.blue, 1'b0};
      default:                    code = '0;
    endcase
  end

  // table contents fixed at elaboration
  for (genvar g = 0; g < 256; g++) begin : g_rom
    assign rom[g] = led_pixel_pkg::brightness_of(led_pixel_pkg::lut_code_t'(g));
  end

  always_ff @(posedge clk) begin
    on_time_o <= rom[code];
  end

endmodule

`default_nettype wire

/* column_scan_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none
`include "led_matrix_defs.svh"

module column_scan_ctrl (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           enable_i,
  input  wire led_bus_pkg::bus_addr_t   frame_base_i,
  output logic                          fetch_start_o,
  output led_bus_pkg::bus_addr_t        fetch_addr_o,
  input  wire                           busy_i,
  input  wire                           fetch_done_i,
  input  wire led_pixel_pkg::on_time_t  on_time_i,
  output led_pixel_pkg::field_e         field_o,
  output logic                          slot_we_o,
  output logic [`LED_PIX_BITS-1:0]      slot_idx_o,
  output led_pixel_pkg::on_time_t       slot_time_o,
  output logic                          line_active_o,
  output logic                          frame_complete_o,
  output logic                          col_first_o,
  output logic                          col_advance_o,
  output logic                          col_rclk_o
);

  localparam logic [3:0] S_REQ   = 4'b0001;
  localparam logic [3:0] S_WAIT  = 4'b0010;
  localparam logic [3:0] S_STORE = 4'b0100;
  localparam logic [3:0] S_LWAIT = 4'b1000;

  localparam int SHIFT_W = $clog2(`LED_SHIFT_PERIOD + 1);
  localparam logic [SHIFT_W-1:0] SHIFT_INIT = SHIFT_W'(`LED_SHIFT_PERIOD);
  localparam logic [SHIFT_W-1:0] SHIFT_HALF = SHIFT_W'(`LED_SHIFT_PERIOD / 2);
  localparam led_pixel_pkg::on_time_t WAIT_INIT = `LED_TIMER_BITS'(`LED_LOAD_WAIT - 1);
  localparam led_pixel_pkg::on_time_t LINE_INIT = `LED_TIMER_BITS'(`LED_LINE_TIME);
  localparam logic [`LED_PIX_BITS-1:0] LAST_PIX = `LED_PIX_BITS'(`LED_N_ROWS - 1);
  localparam logic [`LED_COL_BITS-1:0] LAST_COL = `LED_COL_BITS'(`LED_N_COLS - 1);

  logic [3:0]               state;
  logic [`LED_PIX_BITS-1:0] pix;
  logic [`LED_PIX_BITS-2:0] ypos;
  logic [`LED_COL_BITS-1:0] col;
  led_bus_pkg::bus_addr_t   base_q;
  led_pixel_pkg::on_time_t  wait_cnt;
  led_pixel_pkg::on_time_t  line_cnt;
  logic [SHIFT_W-1:0]       shift_cnt;
  logic                     go;
  logic                     line_start;

  // no new fetch while a line is showing or enable is low
  assign go         = (state == S_REQ) && (line_cnt == '0) && enable_i && !busy_i;
  assign line_start = (state == S_LWAIT) && (wait_cnt == '0) && enable_i;

  // ====================
  // pixel addressing
  // ====================
  // two LEDs per memory row, odd rows swap the pair
  assign ypos = pix[`LED_PIX_BITS-1:1];
  assign fetch_addr_o = base_q
                      + (led_bus_pkg::bus_addr_t'(ypos) << 6)
                      + (led_bus_pkg::bus_addr_t'(col) << 2)
                      + led_bus_pkg::bus_addr_t'({pix[0] ^ ypos[0], 1'b0});

  // ====================
  // load FSM and line timer
  // ====================
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state            <= S_REQ;
      pix              <= '0;
      col              <= '0;
      field_o          <= led_pixel_pkg::FIELD_BLUE;
      base_q           <= `LED_DEFAULT_FRAME;
      wait_cnt         <= '0;
      line_cnt         <= '0;
      fetch_start_o    <= 1'b0;
      frame_complete_o <= 1'b0;
    end else begin
      fetch_start_o <= go;

      if (line_cnt != '0) begin
        line_cnt <= line_cnt - 1'b1;
      end

      // last line cycle, move on to the next pass
      if (line_cnt == `LED_TIMER_BITS'(1)) begin
        case (field_o)
          led_pixel_pkg::FIELD_BLUE:  field_o <= led_pixel_pkg::FIELD_GREEN;
          led_pixel_pkg::FIELD_GREEN: field_o <= led_pixel_pkg::FIELD_RED;
          default: begin
            field_o <= led_pixel_pkg::FIELD_BLUE;
            if (col == LAST_COL) begin
              col    <= '0;
              base_q <= frame_base_i;
            end else begin
              col <= col + 1'b1;
            end
          end
        endcase
      end

      case (state)
        S_REQ:  if (go) state <= S_WAIT;
        S_WAIT: if (fetch_done_i) state <= S_STORE;
        S_STORE: begin
          if (pix == LAST_PIX) begin
            pix      <= '0;
            wait_cnt <= WAIT_INIT;
            state    <= S_LWAIT;
          end else begin
            pix   <= pix + 1'b1;
            state <= S_REQ;
          end
        end
        S_LWAIT: begin
          if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
          end else if (enable_i) begin
            line_cnt <= LINE_INIT;
            state    <= S_REQ;
          end
        end
        default: state <= S_REQ;
      endcase

      if (line_start && col == LAST_COL && field_o == led_pixel_pkg::FIELD_RED) begin
        frame_complete_o <= 1'b1;
      end else if (go) begin
        frame_complete_o <= 1'b0;
      end
    end
  end

  // shift pulse pair for the column register
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      shift_cnt <= '0;
    end else if (line_start) begin
      shift_cnt <= SHIFT_INIT;
    end else if (shift_cnt != '0) begin
      shift_cnt <= shift_cnt - 1'b1;
    end
  end

  assign slot_we_o     = (state == S_STORE);
  assign slot_idx_o    = pix;
  assign slot_time_o   = on_time_i;
  assign line_active_o = (line_cnt != '0);
  assign col_first_o   = (col == '0) && (field_o == led_pixel_pkg::FIELD_BLUE);
  assign col_rclk_o    = (shift_cnt > SHIFT_HALF);
  assign col_advance_o = (shift_cnt != '0) && (shift_cnt <= SHIFT_HALF);

endmodule

`default_nettype wire

/* row_pwm_drive.sv */
`timescale 1ns/1ns
`default_nettype none
`include "led_matrix_defs.svh"

module row_pwm_drive (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           slot_we_i,
  input  wire [`LED_PIX_BITS-1:0]       slot_idx_i,
  input  wire led_pixel_pkg::on_time_t  slot_time_i,
  input  wire                           line_active_i,
  output logic [`LED_BANK_WIDTH-1:0]    row_data_o,
  output logic [`LED_BANKS-1:0]         latch_row_bank_o
);

  led_pixel_pkg::on_time_t               stored [`LED_N_ROWS];
  led_pixel_pkg::on_time_t               active [`LED_N_ROWS];
  logic [`LED_N_ROWS-1:0]                led_q;
  logic [`LED_BANKS*`LED_BANK_WIDTH-1:0] led_word;
  logic [2*`LED_BANKS-1:0]               seq;
  logic                                  line_d;

  always_ff @(posedge clk) begin
    if (slot_we_i && slot_idx_i < `LED_PIX_BITS'(`LED_N_ROWS)) begin
      stored[slot_idx_i] <= slot_time_i;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      line_d <= 1'b0;
    end else begin
      line_d <= line_active_i;
    end
  end

  // ====================
  // per LED countdown
  // ====================
  // copy on the first line cycle, then count down
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      led_q <= '0;
    end else begin
      for (int i = 0; i < `LED_N_ROWS; i++) begin
        led_q[i] <= line_active_i && line_d && (active[i] != '0);
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `LED_N_ROWS; i++) begin
      if (line_active_i && !line_d) begin
        active[i] <= stored[i];
      end else if (line_active_i && active[i] != '0) begin
        active[i] <= active[i] - 1'b1;
      end
    end
  end

  // unused top bits of the last bank stay dark
  assign led_word = {{(`LED_BANKS*`LED_BANK_WIDTH-`LED_N_ROWS){1'b0}}, led_q};

  // ====================
  // bank sequencer
  // ====================
  // two states per bank, strobe on the second
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      seq <= {{(2*`LED_BANKS-1){1'b0}}, 1'b1};
    end else begin
      seq <= {seq[2*`LED_BANKS-2:0], seq[2*`LED_BANKS-1]};
    end
  end

  always_comb begin
    row_data_o       = '0;
    latch_row_bank_o = '0;
    for (int b = 0; b < `LED_BANKS; b++) begin
      if (seq[2*b] || seq[2*b+1]) begin
        row_data_o          = led_word[b*`LED_BANK_WIDTH +: `LED_BANK_WIDTH];
        latch_row_bank_o[b] = seq[2*b+1];
      end
    end
  end

endmodule

`default_nettype wire

/* led_matrix_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "led_matrix_defs.svh"

module led_matrix_top (
  input  wire                           clk,
  input  wire                           rst,
  // host register bus
  input  wire led_bus_pkg::bus_addr_t   wb_adr_i,
  input  wire led_bus_pkg::reg_data_t   wb_dat_i,
  output led_bus_pkg::reg_data_t        wb_dat_o,
  input  wire                           wb_we_i,
  input  wire                           wb_stb_i,
  input  wire                           wb_cyc_i,
  output wire                           wb_ack_o,
  // frame memory
  output led_bus_pkg::bus_addr_t        frame_adr_o,
  input  wire [15:0]                    frame_dat_i,
  output wire                           frame_cyc_o,
  output wire                           frame_stb_o,
  input  wire                           frame_ack_i,
  // matrix drive
  output wire [`LED_BANK_WIDTH-1:0]     row_data_o,
  output wire [`LED_BANKS-1:0]          latch_row_bank_o,
  output wire                           col_first_o,
  output wire                           col_advance_o,
  output wire                           col_rclk_o,
  output wire                           frame_complete_o
);

  led_bus_pkg::bus_addr_t   frame_base;
  led_bus_pkg::bus_addr_t   fetch_addr;
  led_pixel_pkg::pixel_u    pixel;
  led_pixel_pkg::field_e    field;
  led_pixel_pkg::on_time_t  on_time;
  led_pixel_pkg::on_time_t  slot_time;
  logic [`LED_PIX_BITS-1:0] slot_idx;
  logic                     enable;
  logic                     fetch_start;
  logic                     busy;
  logic                     fetch_done;
  logic                     slot_we;
  logic                     line_active;

  led_reg_slave u_regs (
    .clk, .rst, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_we_i, .wb_stb_i, .wb_cyc_i,
    .wb_ack_o, .frame_base_o(frame_base), .enable_o(enable)
  );

  pixel_bus_reader u_reader (
    .clk, .rst, .fetch_start_i(fetch_start), .fetch_addr_i(fetch_addr),
    .busy_o(busy), .fetch_done_o(fetch_done), .pixel_o(pixel),
    .frame_adr_o, .frame_dat_i, .frame_cyc_o, .frame_stb_o, .frame_ack_i
  );

  brightness_lut u_lut (
    .clk, .pixel_i(pixel), .field_i(field), .on_time_o(on_time)
  );

  column_scan_ctrl u_scan (
    .clk, .rst, .enable_i(enable), .frame_base_i(frame_base),
    .fetch_start_o(fetch_start), .fetch_addr_o(fetch_addr), .busy_i(busy),
    .fetch_done_i(fetch_done), .on_time_i(on_time), .field_o(field),
    .slot_we_o(slot_we), .slot_idx_o(slot_idx), .slot_time_o(slot_time),
    .line_active_o(line_active), .frame_complete_o, .col_first_o,
    .col_advance_o, .col_rclk_o
  );

  row_pwm_drive u_rows (
    .clk, .rst, .slot_we_i(slot_we), .slot_idx_i(slot_idx), .slot_time_i(slot_time),
    .line_active_i(line_active), .row_data_o, .latch_row_bank_o
  );

endmodule

`default_nettype wire

/* tb_led_matrix.sv */
`timescale 1ns/1ns
`default_nettype none
`include "led_matrix_defs.svh"

module tb_led_matrix;

  localparam int N_LEDS        = `LED_N_ROWS;
  localparam int FRAME_LINES   = `LED_N_COLS * 3;
  localparam int FRAME_FETCHES = FRAME_LINES * N_LEDS;
  // request to store, worst memory delay included
  localparam int FETCH_MAX     = 10;
  localparam int LINE_MAX      = N_LEDS * FETCH_MAX + `LED_LOAD_WAIT + `LED_LINE_TIME + 8;
  // two frames plus 20 percent
  localparam int WATCHDOG_CYCLES = 2 * FRAME_LINES * LINE_MAX * 12 / 10;
  localparam led_bus_pkg::bus_addr_t REG_CTRL = `LED_BASE_ADDRESS;
  localparam led_bus_pkg::bus_addr_t REG_LO   = `LED_BASE_ADDRESS + 16'h2;
  localparam led_bus_pkg::bus_addr_t REG_HI   = `LED_BASE_ADDRESS + 16'h3;

  // ====================
  // register table
  // ====================
  // address, write, write data, expected read data, expected ack
  localparam int N_TBL = 15;
  localparam logic [15:0] TBL_ADR [N_TBL] = '{
    16'h0100, 16'h0102, 16'h0103, 16'h0102, 16'h0102, 16'h0103, 16'h0103, 16'h0101,
    16'h0101, 16'h0200, 16'h0200, 16'h0100, 16'h010F, 16'h1102, 16'h0102};
  localparam logic TBL_WE [N_TBL] = '{
    1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
  localparam logic [7:0] TBL_WDAT [N_TBL] = '{
    8'h00, 8'h00, 8'h00, 8'h68, 8'h00, 8'h24, 8'h00, 8'h00,
    8'hFF, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
  localparam logic [7:0] TBL_RDAT [N_TBL] = '{
    8'h01, 8'h00, 8'h80, 8'h00, 8'h68, 8'h00, 8'h24, 8'h00,
    8'h00, 8'h00, 8'h00, 8'h01, 8'h00, 8'h00, 8'h68};
  localparam logic TBL_ACK [N_TBL] = '{
    1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};

  logic                   clk;
  logic                   rst;
  led_bus_pkg::bus_addr_t wb_adr;
  led_bus_pkg::reg_data_t wb_dat_w;
  led_bus_pkg::reg_data_t wb_dat_r;
  logic                   wb_we;
  logic                   wb_stb;
  logic                   wb_cyc;
  logic                   wb_ack;
  led_bus_pkg::bus_addr_t frame_adr;
  logic [15:0]            frame_dat;
  logic                   frame_cyc;
  logic                   frame_stb;
  logic                   frame_ack;
  logic [7:0]             row_data;
  logic [3:0]             latch_bank;
  logic                   col_first;
  logic                   col_advance;
  logic                   col_rclk;
  logic                   frame_complete;

  led_bus_pkg::bus_addr_t shadow_base;
  led_bus_pkg::bus_addr_t expected_base;
  led_bus_pkg::bus_addr_t exp_adr;
  logic [15:0]            line_words [N_LEDS];
  int                     led_hits [N_LEDS];
  int fetch_count, lines_checked, mem_delay, idx, line, col, y, bank, last_bank, since_latch;
  int col_first_rises, frame_complete_rises, paused_count, rclk_cycles, advance_cycles;
  int checks, err_reg, err_addr, err_time, err_bit, err_total;
  logic col_first_q;
  logic frame_complete_q;

  led_matrix_top DUT (
    .clk, .rst, .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r),
    .wb_we_i(wb_we), .wb_stb_i(wb_stb), .wb_cyc_i(wb_cyc), .wb_ack_o(wb_ack),
    .frame_adr_o(frame_adr), .frame_dat_i(frame_dat), .frame_cyc_o(frame_cyc),
    .frame_stb_o(frame_stb), .frame_ack_i(frame_ack), .row_data_o(row_data),
    .latch_row_bank_o(latch_bank), .col_first_o(col_first), .col_advance_o(col_advance),
    .col_rclk_o(col_rclk), .frame_complete_o(frame_complete)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ====================
  // compare tasks
  // ====================
  task automatic check_reg(input string name, input led_bus_pkg::reg_data_t got,
                           input led_bus_pkg::reg_data_t exp);
    checks++;
    if (got !== exp) begin
      err_reg++;
      $display("FAILED t=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input led_bus_pkg::bus_addr_t got,
                            input led_bus_pkg::bus_addr_t exp);
    checks++;
    if (got !== exp) begin
      err_addr++;
      $display("FAILED t=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_time(input string name, input led_pixel_pkg::on_time_t got,
                            input led_pixel_pkg::on_time_t exp, input int tol);
    int diff;
    diff = int'(got) - int'(exp);
    checks++;
    if (diff > tol || diff < -tol) begin
      err_time++;
      $display("FAILED t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      err_bit++;
      $display("FAILED t=%0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  // frame memory contents, mixes every address bit
  function automatic logic [15:0] pixel_at(input led_bus_pkg::bus_addr_t adr);
    return (adr * 16'h9E37) ^ {adr[7:0], adr[15:8]};
  endfunction

  // field 0 blue, 1 green, 2 red; square law over 16
  function automatic int expected_on_time(input logic [15:0] word, input int field_sel);
    int code;
    case (field_sel)
      0:       code = 2 * int'(word[4:0]);
      1:       code = int'(word[10:5]);
      default: code = 2 * int'(word[15:11]);
    endcase
    return (code * code) / 16;
  endfunction

  task automatic evaluate_line(input int line_no);
    int t;
    for (int i = 0; i < N_LEDS; i++) begin
      t = expected_on_time(line_words[i], line_no % 3);
      check_time($sformatf("line %0d led %0d latched on-time/8", line_no, i),
                 led_pixel_pkg::on_time_t'(led_hits[i]), led_pixel_pkg::on_time_t'(t / 8), 1);
      led_hits[i] = 0;
    end
    // one shift pulse pair per line, each half of the period
    check_bit($sformatf("line %0d col_rclk_o high cycles", line_no),
              rclk_cycles == `LED_SHIFT_PERIOD / 2, 1'b1);
    check_bit($sformatf("line %0d col_advance_o high cycles", line_no),
              advance_cycles == `LED_SHIFT_PERIOD / 2, 1'b1);
    rclk_cycles = 0;
    advance_cycles = 0;
    lines_checked++;
  endtask

  task automatic bus_access(input led_bus_pkg::bus_addr_t adr, input logic we,
                            input led_bus_pkg::reg_data_t wdat,
                            input led_bus_pkg::reg_data_t exp_rdat, input logic exp_ack);
    @(posedge clk);
    wb_adr   <= adr;
    wb_dat_w <= wdat;
    wb_we    <= we;
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    @(negedge clk);
    if (!we) begin
      check_reg($sformatf("wb_dat_o @%h", adr), wb_dat_r, exp_rdat);
    end
    check_bit("wb_ack_o in request cycle", wb_ack, 1'b0);
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    @(negedge clk);
    check_bit($sformatf("wb_ack_o @%h", adr), wb_ack, exp_ack);
    check_reg("wb_dat_o when idle", wb_dat_r, 8'h00);
    @(negedge clk);
    check_bit("wb_ack_o second cycle", wb_ack, 1'b0);
    if (we && adr == REG_LO) begin
      shadow_base[7:0] = wdat;
    end else if (we && adr == REG_HI) begin
      shadow_base[15:8] = wdat;
    end
  endtask

  task automatic wait_fetches(input int n);
    while (fetch_count < n) begin
      @(posedge clk);
    end
  endtask

  // ====================
  // memory model and monitors
  // ====================
  always @(posedge clk) begin
    if (rst) begin
      frame_ack <= 1'b0;
      col_first_q = col_first;
      frame_complete_q = frame_complete;
    end else begin
      if (col_first && !col_first_q) begin
        check_bit("col_first_o rise at frame end", (fetch_count % FRAME_FETCHES) == 0, 1'b1);
        expected_base = shadow_base;
        col_first_rises++;
      end
      if (frame_complete && !frame_complete_q) begin
        check_bit("frame_complete_o rise on last line",
                  fetch_count > 0 && (fetch_count % FRAME_FETCHES) == 0, 1'b1);
        frame_complete_rises++;
      end
      check_bit("col_rclk_o with col_advance_o", col_rclk && col_advance, 1'b0);
      if (col_rclk) begin
        check_bit("col_rclk_o before col_advance_o", advance_cycles == 0, 1'b1);
        rclk_cycles++;
      end
      if (col_advance) begin
        advance_cycles++;
      end
      col_first_q = col_first;
      frame_complete_q = frame_complete;

      if (latch_bank != 4'b0000) begin
        check_bit("latch_row_bank_o one-hot", $onehot(latch_bank), 1'b1);
        for (int b = 0; b < 4; b++) begin
          if (latch_bank[b]) bank = b;
        end
        if (last_bank >= 0) begin
          check_bit("latch_row_bank_o order", bank == (last_bank + 1) % 4, 1'b1);
          check_bit("latch_row_bank_o spacing", since_latch == 2, 1'b1);
        end
        for (int j = 0; j < 8; j++) begin
          if (bank * 8 + j < N_LEDS) begin
            led_hits[bank * 8 + j] += int'(row_data[j]);
          end else begin
            check_bit($sformatf("row_data_o unused bit %0d", j), row_data[j], 1'b0);
          end
        end
        last_bank = bank;
        since_latch = 0;
      end
      since_latch++;

      // ack after 0 to 3 wait cycles
      if (frame_ack) begin
        frame_ack <= 1'b0;
      end else if (frame_cyc && frame_stb) begin
        if (mem_delay != 0) begin
          mem_delay = mem_delay - 1;
        end else begin
          idx  = fetch_count % N_LEDS;
          line = fetch_count / N_LEDS;
          col  = (line / 3) % `LED_N_COLS;
          y    = idx / 2;
          if (idx == 0 && line > 0) begin
            evaluate_line(line - 1);
          end
          exp_adr = expected_base
                  + led_bus_pkg::bus_addr_t'(64 * y + 4 * col + 2 * ((idx % 2) ^ (y % 2)));
          check_addr($sformatf("frame_adr_o line %0d pixel %0d", line, idx), frame_adr, exp_adr);
          line_words[idx] = pixel_at(frame_adr);
          frame_dat <= pixel_at(frame_adr);
          frame_ack <= 1'b1;
          fetch_count++;
        end
      end else begin
        mem_delay = $urandom % 4;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the scan did not reach the end", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  // ====================
  // main sequence
  // ====================
  initial begin
    rst = 1'b1;
    wb_adr = '0;
    wb_dat_w = '0;
    wb_we = 1'b0;
    wb_stb = 1'b0;
    wb_cyc = 1'b0;
    frame_dat = '0;
    frame_ack = 1'b0;
    shadow_base = `LED_DEFAULT_FRAME;
    expected_base = `LED_DEFAULT_FRAME;
    last_bank = -1;
    for (int i = 0; i < N_LEDS; i++) begin
      led_hits[i] = 0;
    end
    void'($urandom(47096));
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    wait_fetches(1);
    for (int r = 0; r < N_TBL; r++) begin
      bus_access(TBL_ADR[r], TBL_WE[r], TBL_WDAT[r], TBL_RDAT[r], TBL_ACK[r]);
    end

    // new base only after the frame wraps
    wait_fetches(FRAME_FETCHES + 3 * N_LEDS);
    check_addr("latched frame base", expected_base, 16'h2468);

    bus_access(REG_CTRL, 1'b1, 8'h00, 8'h00, 1'b1);
    repeat (LINE_MAX) @(posedge clk);
    @(negedge clk);
    paused_count = fetch_count;
    repeat (LINE_MAX) @(posedge clk);
    @(negedge clk);
    check_bit("no fetch while disabled", fetch_count == paused_count, 1'b1);
    check_bit("frame_cyc_o while disabled", frame_cyc, 1'b0);
    bus_access(REG_CTRL, 1'b1, 8'h01, 8'h00, 1'b1);
    wait_fetches(paused_count + 2 * N_LEDS);
    @(negedge clk);

    check_bit("single col_first_o rise", col_first_rises == 1, 1'b1);
    check_bit("single frame_complete_o rise", frame_complete_rises == 1, 1'b1);
    check_bit("enough lines checked", lines_checked > FRAME_LINES, 1'b1);

    err_total = err_reg + err_addr + err_time + err_bit;
    $display("checks %0d, errors %0d: reg %0d, addr %0d, time %0d, bit %0d",
             checks, err_total, err_reg, err_addr, err_time, err_bit);
    if (err_total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
led_bus_pkg.sv
led_pixel_pkg.sv
led_reg_slave.sv
pixel_bus_reader.sv
brightness_lut.sv
column_scan_ctrl.sv
row_pwm_drive.sv
led_matrix_top.sv
tb_led_matrix.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_led_matrix
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_TEXT ?= All tests passed

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard *.sv) $(wildcard *.svh) $(FILELIST)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
